// File: hdl/rib_pkg.sv
// shared widths, bus types and default words for the rib interconnect, imported by every rib block
package rib_pkg;

    // bus geometry
    localparam int ADDR_W      = 32;                     // byte address width
    localparam int DATA_W      = 32;                     // data word width
    localparam int REGION_W    = 4;                      // top nibble picks the slave
    localparam int REGION_LSB  = ADDR_W - REGION_W;      // first bit of the region field
    localparam int MASTER_ID_W = 2;                      // enough for four masters
    localparam int SLAVE_ID_W  = REGION_W;               // one slave index per region

    // bus types
    typedef logic [ADDR_W-1:0]      addr_t;              // bus address
    typedef logic [DATA_W-1:0]      word_t;              // bus data word
    typedef logic [REGION_W-1:0]    region_t;            // region nibble of an address
    typedef logic [MASTER_ID_W-1:0] master_id_t;         // master index
    typedef logic [SLAVE_ID_W-1:0]  slave_id_t;          // slave index

    // system size
    localparam int NUM_MASTERS = 4;                      // fixed, priority order names each one
    localparam int MAX_SLAVES  = 2 ** REGION_W;          // number of regions

    // master 1 is the core's instruction fetch port
    localparam master_id_t FETCH_MASTER = 2'd1;          // holds the bus when idle

    // default read values
    localparam word_t ZERO_WORD = 32'h0000_0000;         // data and non-fetch default
    localparam word_t NOP_INST  = 32'h0000_0013;         // addi x0, x0, 0

endpackage

// File: hdl/rib_req_if.sv
// carries the winning master's request from the rib arbiter to the decoder and response mux
`timescale 1ns/1ps

interface rib_req_if import rib_pkg::*; ();

    logic       valid;                  // some master requests
    master_id_t grant;                  // index of the winner
    addr_t      addr;                   // winner's full address
    word_t      wdata;                  // winner's write word
    logic       we;                     // winner's write enable level

    // arbiter produces the granted request
    modport arb (
        output valid, grant, addr, wdata, we
    );

    // decoder needs the whole request
    modport dec (
        input  valid, grant, addr, wdata, we
    );

    // response side only needs to know who owns the bus
    modport rsp (
        input  valid, grant
    );

endinterface

// File: hdl/rib_arbiter.sv
// fixed-priority arbiter of the rib bus that picks one master and raises the core stall flag
`timescale 1ns/1ps

module rib_arbiter import rib_pkg::*; (
    input  logic   clk_i,                            // assertion clock only
    input  logic   arst_n_i,                         // assertions off while low
    input  logic   m_req_i   [NUM_MASTERS],          // request levels per master
    input  addr_t  m_addr_i  [NUM_MASTERS],          // access addresses
    input  word_t  m_wdata_i [NUM_MASTERS],          // write words
    input  logic   m_we_i    [NUM_MASTERS],          // write enables
    rib_req_if.arb req,                              // granted request
    output logic   hold_flag_o                       // stall the core pipeline
);

    // highest priority first
    localparam master_id_t PRIO_ORDER [NUM_MASTERS] = '{2'd3, 2'd0, 2'd2, 2'd1};

    master_id_t grant;                               // winner
    logic       any_req;                             // at least one request present
    logic       other_req;                           // a non-fetch master requests

    // walk up from the lowest priority so the highest hit is kept
    always_comb begin
        grant   = FETCH_MASTER;                      // fetch port owns an idle bus
        any_req = 1'b0;
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
            if (m_req_i[PRIO_ORDER[i]]) begin
                grant   = PRIO_ORDER[i];
                any_req = 1'b1;
            end
        end
    end

    // requests from anyone but the fetch port
    always_comb begin
        other_req = 1'b0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (master_id_t'(i) != FETCH_MASTER) begin
                other_req = other_req | m_req_i[i];
            end
        end
    end

    // forward the winner
    assign req.valid = any_req;
    assign req.grant = grant;
    assign req.addr  = m_addr_i[grant];              // full address, region still set
    assign req.wdata = m_wdata_i[grant];
    assign req.we    = m_we_i[grant];                // level, no handshake

    // stall whenever the fetch port loses the bus
    assign hold_flag_o = any_req && (grant != FETCH_MASTER);

    // a grant must land on a master that is really asking
    a_grant_owns_req: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        req.valid |-> m_req_i[req.grant]
    ) else $error("rib_arbiter: grant to idle master %0d", req.grant);

    // fetch port alone must never stall the core
    a_fetch_no_hold: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (m_req_i[FETCH_MASTER] && !other_req) |-> !hold_flag_o
    ) else $error("rib_arbiter: hold raised for lone fetch request");

endmodule

// File: hdl/rib_decoder.sv
// region decoder of the rib bus that steers the granted request to exactly one slave port
`timescale 1ns/1ps

module rib_decoder import rib_pkg::*; #(
    parameter int NUM_SLAVES = 8                     // slaves on regions 0 .. NUM_SLAVES-1
) (
    input  logic      clk_i,                         // assertion clock only
    input  logic      arst_n_i,                      // assertions off while low
    rib_req_if.dec    req,                           // granted request
    output addr_t     s_addr_o  [NUM_SLAVES],        // slave-local addresses
    output word_t     s_wdata_o [NUM_SLAVES],        // slave write words
    output logic      s_we_o    [NUM_SLAVES],        // slave write enables
    output logic      hit_o,                         // region has a slave behind it
    output slave_id_t sel_o                          // selected slave index
);

    // slave count has to fit the region field
    if (NUM_SLAVES < 1 || NUM_SLAVES > MAX_SLAVES) begin : g_bad_num_slaves
        $error("rib_decoder: NUM_SLAVES %0d outside 1..%0d", NUM_SLAVES, MAX_SLAVES);
    end

    region_t                 region;                 // top nibble of the granted address
    addr_t                   local_addr;             // address seen by the slave
    logic                    drive_en;               // valid request to an existing slave
    logic [NUM_SLAVES-1:0]   we_vec;                 // packed copy of the write enables

    assign region     = req.addr[ADDR_W-1:REGION_LSB];
    assign local_addr = {{REGION_W{1'b0}}, req.addr[REGION_LSB-1:0]};    // region cleared

    assign sel_o    = slave_id_t'(region);
    assign hit_o    = (int'(region) < NUM_SLAVES);   // regions above the count are unmapped
    assign drive_en = req.valid && hit_o;

    // one port per slave, quiet unless selected
    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
        logic slave_sel;                             // this slave owns the access

        assign slave_sel    = drive_en && (sel_o == slave_id_t'(s));
        assign s_addr_o[s]  = slave_sel ? local_addr : addr_t'(ZERO_WORD);
        assign s_wdata_o[s] = slave_sel ? req.wdata : ZERO_WORD;
        assign s_we_o[s]    = slave_sel && req.we;
        assign we_vec[s]    = s_we_o[s];
    end

    // a write may reach at most one slave
    a_we_onehot: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(we_vec)
    ) else $error("rib_decoder: several slave write enables high %b", we_vec);

endmodule

// File: hdl/rib_response_mux.sv
// read-data return path of the rib bus, routes the selected slave to the granted master
`timescale 1ns/1ps

module rib_response_mux import rib_pkg::*; #(
    parameter int NUM_SLAVES = 8                     // slave ports present
) (
    input  logic      clk_i,                         // assertion clock only
    input  logic      arst_n_i,                      // assertions off while low
    rib_req_if.rsp    req,                           // who owns the bus
    input  logic      hit_i,                         // decoder found a slave
    input  slave_id_t sel_i,                         // decoder's slave index
    input  word_t     s_rdata_i [NUM_SLAVES],        // slave read words
    output word_t     m_rdata_o [NUM_MASTERS]        // master read words
);

    word_t sel_rdata;                                // read word of the selected slave
    logic  rsp_en;                                   // a real return exists

    assign rsp_en = req.valid && hit_i;

    // mux over present slaves only
    always_comb begin
        sel_rdata = ZERO_WORD;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (sel_i == slave_id_t'(s)) begin
                sel_rdata = s_rdata_i[s];
            end
        end
    end

    // fetch port reads a nop so the pipeline keeps flowing
    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
        localparam word_t DEFAULT_WORD = (m == FETCH_MASTER) ? NOP_INST : ZERO_WORD;

        logic owns_rsp;                              // this master gets the slave word

        assign owns_rsp     = rsp_en && (req.grant == master_id_t'(m));
        assign m_rdata_o[m] = owns_rsp ? sel_rdata : DEFAULT_WORD;

        // masters off the bus see only their default word
        a_idle_default: assert property (
            @(posedge clk_i) disable iff (!arst_n_i)
            (!req.valid || req.grant != master_id_t'(m)) |->
                (m_rdata_o[m] == ((m == FETCH_MASTER) ? NOP_INST : ZERO_WORD))
        ) else $error("rib_response_mux: master %0d read %h off the bus", m, m_rdata_o[m]);
    end

endmodule

// File: hdl/rib_top.sv
// top level of the rib interconnect that joins four masters to up to sixteen slaves
`timescale 1ns/1ps

module rib_top import rib_pkg::*; #(
    parameter int NUM_SLAVES = 8                     // slaves on the low regions
) (
    input  logic  clk_i,                             // assertion clock
    input  logic  arst_n_i,                          // async active-low reset

    // master side
    input  logic  m_req_i   [NUM_MASTERS],           // request levels
    input  addr_t m_addr_i  [NUM_MASTERS],           // access addresses
    input  word_t m_wdata_i [NUM_MASTERS],           // write words
    input  logic  m_we_i    [NUM_MASTERS],           // write enables
    output word_t m_rdata_o [NUM_MASTERS],           // read words

    // slave side
    output addr_t s_addr_o  [NUM_SLAVES],            // region-cleared addresses
    output word_t s_wdata_o [NUM_SLAVES],            // write words
    output logic  s_we_o    [NUM_SLAVES],            // write enables
    input  word_t s_rdata_i [NUM_SLAVES],            // read words

    output logic  hold_flag_o                        // core stall request
);

    rib_req_if req_if ();                            // granted request bundle

    logic      hit;                                  // decoded region has a slave
    slave_id_t sel;                                  // decoded slave index

    // pick the master
    rib_arbiter u_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .m_req_i     (m_req_i),
        .m_addr_i    (m_addr_i),
        .m_wdata_i   (m_wdata_i),
        .m_we_i      (m_we_i),
        .req         (req_if.arb),
        .hold_flag_o (hold_flag_o)
    );

    // steer the request to one slave
    rib_decoder #(
        .NUM_SLAVES (NUM_SLAVES)
    ) u_decoder (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .req       (req_if.dec),
        .s_addr_o  (s_addr_o),
        .s_wdata_o (s_wdata_o),
        .s_we_o    (s_we_o),
        .hit_o     (hit),
        .sel_o     (sel)
    );

    // bring read data back
    rib_response_mux #(
        .NUM_SLAVES (NUM_SLAVES)
    ) u_rsp_mux (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .req       (req_if.rsp),
        .hit_i     (hit),
        .sel_i     (sel),
        .s_rdata_i (s_rdata_i),
        .m_rdata_o (m_rdata_o)
    );

endmodule

// File: testbench/rib_tb.sv
// testbench for the rib interconnect, replays the hex pattern file against rib_top and checks it
`timescale 1ns/1ps

module rib_tb import rib_pkg::*; ();

    localparam int    NUM_SLAVES    = 8;                     // dut slave count
    localparam int    CLK_PERIOD    = 10;                    // ns
    localparam int    RESET_CYCLES  = 3;                     // cycles with arst_n_i low
    localparam int    DRIVE_DELAY   = 1;                     // ns after the rising edge
    localparam int    RESET_TIMEOUT = 20;                    // cycles allowed for reset release
    localparam string PATTERN_FILE  = "testbench/rib_patterns.txt";

    // dut ports
    logic  clk_i;
    logic  arst_n_i;
    logic  m_req_i   [NUM_MASTERS];
    addr_t m_addr_i  [NUM_MASTERS];
    word_t m_wdata_i [NUM_MASTERS];
    logic  m_we_i    [NUM_MASTERS];
    word_t m_rdata_o [NUM_MASTERS];
    addr_t s_addr_o  [NUM_SLAVES];
    word_t s_wdata_o [NUM_SLAVES];
    logic  s_we_o    [NUM_SLAVES];
    word_t s_rdata_i [NUM_SLAVES];
    logic  hold_flag_o;

    // next stimulus, parsed ahead of the drive edge
    logic [NUM_MASTERS-1:0] req_v;                           // bit m is master m's request
    logic [NUM_MASTERS-1:0] we_v;                            // bit m is master m's write enable
    addr_t                  nxt_addr  [NUM_MASTERS];
    word_t                  nxt_wdata [NUM_MASTERS];

    // expected response of the current case
    logic  exp_hold;
    logic  exp_hit;                                          // some slave is driven
    int    exp_sel;                                          // index of that slave
    addr_t exp_saddr;                                        // its region-cleared address
    word_t exp_swdata;
    logic  exp_swe;
    word_t exp_rdata [NUM_MASTERS];

    int fd;                                                  // pattern file handle
    int case_cnt;                                            // cases checked so far

    rib_top #(
        .NUM_SLAVES (NUM_SLAVES)
    ) dut_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .m_req_i     (m_req_i),
        .m_addr_i    (m_addr_i),
        .m_wdata_i   (m_wdata_i),
        .m_we_i      (m_we_i),
        .m_rdata_o   (m_rdata_o),
        .s_addr_o    (s_addr_o),
        .s_wdata_o   (s_wdata_o),
        .s_we_o      (s_we_o),
        .s_rdata_i   (s_rdata_i),
        .hold_flag_o (hold_flag_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;            // 10 ns period
    end

    initial begin
        arst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        arst_n_i = 1'b1;                                     // release off the edge
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    // next line that is neither blank nor a # comment
    task automatic read_data_line(output string line, output bit found);
        int n;
        found = 1'b0;
        line  = "";
        while (!found && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                found = 1'b1;
            end
        end
    endtask

    task automatic read_slave_tags();
        string line;
        bit    found;
        word_t tag;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            read_data_line(line, found);
            if (!found) begin
                stop_on_error("pattern file ends before all slave read tags are given");
            end else if ($sscanf(line, "%h", tag) != 1) begin
                stop_on_error($sformatf("slave read tag %0d is not a hex word", s));
            end else begin
                s_rdata_i[s] = tag;                          // held for the whole run
            end
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (arst_n_i !== 1'b1) begin
            if (cycles >= RESET_TIMEOUT) begin
                stop_on_error("reset was not released within the allowed cycles");
            end else begin
                @(posedge clk_i);
                cycles++;
            end
        end
    endtask

    // stimulus and expectations of one case, a dash means no slave is driven
    task automatic parse_case(input string line);
        string sel_txt;
        int    n;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %s %h %h %h %h %h %h %h",
                    req_v, nxt_addr[0], nxt_addr[1], nxt_addr[2], nxt_addr[3],
                    nxt_wdata[0], nxt_wdata[1], nxt_wdata[2], nxt_wdata[3], we_v,
                    exp_hold, sel_txt, exp_saddr, exp_swdata, exp_swe,
                    exp_rdata[0], exp_rdata[1], exp_rdata[2], exp_rdata[3]);
        if (n != 19) begin
            stop_on_error($sformatf("pattern case %0d is truncated or malformed", case_cnt + 1));
        end else if (sel_txt == "-") begin
            exp_hit = 1'b0;
            exp_sel = 0;
        end else begin
            exp_hit = 1'b1;
            exp_sel = sel_txt.atoi();
            if (exp_sel < 0 || exp_sel >= NUM_SLAVES) begin
                stop_on_error($sformatf("pattern case %0d names slave %s, which does not exist",
                                        case_cnt + 1, sel_txt));
            end
        end
    endtask

    task automatic apply_case();
        @(posedge clk_i);
        #DRIVE_DELAY;                                        // clear of the edge
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_req_i[m]   = req_v[m];
            m_addr_i[m]  = nxt_addr[m];
            m_wdata_i[m] = nxt_wdata[m];
            m_we_i[m]    = we_v[m];
        end
    endtask

    // only the expected slave may see traffic, all others stay at zero
    task automatic verify_outputs();
        check_bit("hold_flag_o", hold_flag_o, exp_hold);
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (exp_hit && s == exp_sel) begin
                check_addr($sformatf("s_addr_o[%0d]", s), s_addr_o[s], exp_saddr);
                check_word($sformatf("s_wdata_o[%0d]", s), s_wdata_o[s], exp_swdata);
                check_bit($sformatf("s_we_o[%0d]", s), s_we_o[s], exp_swe);
            end else begin
                check_addr($sformatf("s_addr_o[%0d]", s), s_addr_o[s], addr_t'(ZERO_WORD));
                check_word($sformatf("s_wdata_o[%0d]", s), s_wdata_o[s], ZERO_WORD);
                check_bit($sformatf("s_we_o[%0d]", s), s_we_o[s], 1'b0);
            end
        end
        for (int m = 0; m < NUM_MASTERS; m++) begin
            check_word($sformatf("m_rdata_o[%0d]", m), m_rdata_o[m], exp_rdata[m]);
        end
    endtask

    initial begin : main_seq
        string line;
        bit    found;
        for (int m = 0; m < NUM_MASTERS; m++) begin     // bus idle from time zero
            m_req_i[m]   = 1'b0;
            m_addr_i[m]  = addr_t'(ZERO_WORD);
            m_wdata_i[m] = ZERO_WORD;
            m_we_i[m]    = 1'b0;
        end
        for (int s = 0; s < NUM_SLAVES; s++) begin
            s_rdata_i[s] = ZERO_WORD;
        end
        case_cnt = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            stop_on_error("cannot open the pattern file testbench/rib_patterns.txt");
        end
        read_slave_tags();
        wait_reset_release();

        // idle bus right after reset
        @(negedge clk_i);
        exp_hold     = 1'b0;
        exp_hit      = 1'b0;
        exp_sel      = 0;
        exp_saddr    = addr_t'(ZERO_WORD);
        exp_swdata   = ZERO_WORD;
        exp_swe      = 1'b0;
        exp_rdata[0] = 32'h0000_0000;                        // data masters read zero
        exp_rdata[1] = 32'h0000_0013;                        // fetch port sees addi x0, x0, 0
        exp_rdata[2] = 32'h0000_0000;
        exp_rdata[3] = 32'h0000_0000;
        verify_outputs();

        read_data_line(line, found);
        while (found) begin
            parse_case(line);
            apply_case();
            @(negedge clk_i);                                // outputs settled mid-cycle
            verify_outputs();
            case_cnt++;
            read_data_line(line, found);
        end
        $fclose(fd);

        if (case_cnt == 0) begin
            stop_on_error("the pattern file holds no test cases");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// File: project.f
hdl/rib_pkg.sv
hdl/rib_req_if.sv
hdl/rib_arbiter.sv
hdl/rib_decoder.sv
hdl/rib_response_mux.sv
hdl/rib_top.sv
testbench/rib_tb.sv

// File: testbench/rib_patterns.txt
# rib vectors in hex; the first 8 data lines are the read tags of slaves 0 to 7
# req a0 a1 a2 a3 w0 w1 w2 w3 we hold sel(- none) s_addr s_wdata s_we r0 r1 r2 r3
# slave read tags
c0de0000
c0de0001
c0de0002
c0de0003
c0de0004
c0de0005
c0de0006
c0de0007
# idle
0 0 0 0 0 0 0 0 0 0 0 - 0 0 0 0 13 0 0
# every request combination, masters 0 and 2 writing
0 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 0 - 0 0 0 0 13 0 0
1 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 2 100 a0 1 c0de0002 13 0 0
2 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 0 1 40 a1 0 0 c0de0001 0 0
3 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 2 100 a0 1 c0de0002 13 0 0
4 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 4 200 a2 1 0 13 c0de0004 0
5 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 2 100 a0 1 c0de0002 13 0 0
6 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 4 200 a2 1 0 13 c0de0004 0
7 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 2 100 a0 1 c0de0002 13 0 0
8 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 3 300 a3 0 0 13 0 c0de0003
9 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 3 300 a3 0 0 13 0 c0de0003
a 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 3 300 a3 0 0 13 0 c0de0003
b 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 3 300 a3 0 0 13 0 c0de0003
c 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 3 300 a3 0 0 13 0 c0de0003
d 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 3 300 a3 0 0 13 0 c0de0003
e 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 3 300 a3 0 0 13 0 c0de0003
f 20000100 10000040 40000200 30000300 a0 a1 a2 a3 5 1 3 300 a3 0 0 13 0 c0de0003
# every request combination again, masters 1 and 3 writing
0 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 0 - 0 0 0 0 13 0 0
1 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 5 c b0 0 c0de0005 13 0 0
2 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 0 0 abc0 b1 1 0 c0de0000 0 0
3 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 5 c b0 0 c0de0005 13 0 0
4 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 6 ffffff0 b2 0 0 13 c0de0006 0
5 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 5 c b0 0 c0de0005 13 0 0
6 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 6 ffffff0 b2 0 0 13 c0de0006 0
7 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 5 c b0 0 c0de0005 13 0 0
8 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 7 8 b3 1 0 13 0 c0de0007
9 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 7 8 b3 1 0 13 0 c0de0007
a 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 7 8 b3 1 0 13 0 c0de0007
b 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 7 8 b3 1 0 13 0 c0de0007
c 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 7 8 b3 1 0 13 0 c0de0007
d 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 7 8 b3 1 0 13 0 c0de0007
e 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 7 8 b3 1 0 13 0 c0de0007
f 5000000c 0000abc0 6ffffff0 70000008 b0 b1 b2 b3 a 1 7 8 b3 1 0 13 0 c0de0007
# fetch master alone walks all sixteen regions, 8 to f are unmapped
2 20000004 01234560 40000008 3000000c c0 50 c2 c3 f 0 0 1234560 50 1 0 c0de0000 0 0
2 20000004 11234560 40000008 3000000c c0 51 c2 c3 5 0 1 1234560 51 0 0 c0de0001 0 0
2 20000004 21234560 40000008 3000000c c0 52 c2 c3 f 0 2 1234560 52 1 0 c0de0002 0 0
2 20000004 31234560 40000008 3000000c c0 53 c2 c3 5 0 3 1234560 53 0 0 c0de0003 0 0
2 20000004 41234560 40000008 3000000c c0 54 c2 c3 f 0 4 1234560 54 1 0 c0de0004 0 0
2 20000004 51234560 40000008 3000000c c0 55 c2 c3 5 0 5 1234560 55 0 0 c0de0005 0 0
2 20000004 61234560 40000008 3000000c c0 56 c2 c3 f 0 6 1234560 56 1 0 c0de0006 0 0
2 20000004 71234560 40000008 3000000c c0 57 c2 c3 5 0 7 1234560 57 0 0 c0de0007 0 0
2 20000004 81234560 40000008 3000000c c0 58 c2 c3 f 0 - 0 0 0 0 13 0 0
2 20000004 91234560 40000008 3000000c c0 59 c2 c3 5 0 - 0 0 0 0 13 0 0
2 20000004 a1234560 40000008 3000000c c0 5a c2 c3 f 0 - 0 0 0 0 13 0 0
2 20000004 b1234560 40000008 3000000c c0 5b c2 c3 5 0 - 0 0 0 0 13 0 0
2 20000004 c1234560 40000008 3000000c c0 5c c2 c3 f 0 - 0 0 0 0 13 0 0
2 20000004 d1234560 40000008 3000000c c0 5d c2 c3 5 0 - 0 0 0 0 13 0 0
2 20000004 e1234560 40000008 3000000c c0 5e c2 c3 f 0 - 0 0 0 0 13 0 0
2 20000004 f1234560 40000008 3000000c c0 5f c2 c3 5 0 - 0 0 0 0 13 0 0
# unmapped writes, address extremes, shared slaves and idle with busy inputs
8 0 0 0 9000abcd 0 0 0 77 8 1 - 0 0 0 0 13 0 0
1 ffffffff 0 0 0 dead 0 0 0 1 1 - 0 0 0 0 13 0 0
4 0 0 80000010 0 0 0 99 0 4 1 - 0 0 0 0 13 0 0
1 0fffffff 0 0 0 12345678 0 0 0 1 1 0 fffffff 12345678 1 c0de0000 13 0 0
4 0 0 7fffffff 0 0 0 cafef00d 0 4 1 7 fffffff cafef00d 1 0 13 c0de0007 0
a 0 10000040 0 8000ffff 0 a1 0 a3 a 1 - 0 0 0 0 13 0 0
3 10000abc 10000040 0 0 e0 e1 0 0 3 1 1 abc e0 1 c0de0001 13 0 0
c 0 0 60000020 60000030 0 0 f2 f3 c 1 6 30 f3 1 0 13 0 c0de0006
0 ffffffff ffffffff ffffffff ffffffff 1 2 3 4 f 0 - 0 0 0 0 13 0 0
2 0 30000008 0 0 0 42 0 0 2 0 3 8 42 1 0 c0de0003 0 0
